// ==== Makefile ====
TOP = robot_car_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q '^\*\*\* FAILED \*\*\*' sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '^\*\*\* PASSED \*\*\*' sim.log; then echo "Simulation incomplete"; exit 1; fi

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== dv/car_model.svh ====
`ifndef CAR_MODEL_SVH
`define CAR_MODEL_SVH

// Any mode key selects its own mode, other keys leave it.
function automatic car_pkg::mode_t next_mode(car_pkg::mode_t m, logic [7:0] code);
    case (code)
        car_pkg::KEY_CAM:  return car_pkg::MODE_CAM;
        car_pkg::KEY_IR:   return car_pkg::MODE_IR;
        car_pkg::KEY_IDLE: return car_pkg::MODE_IDLE;
        default:           return m;
    endcase
endfunction

function automatic logic [car_pkg::GEAR_W-1:0] next_gear(logic [car_pkg::GEAR_W-1:0] g,
                                                         logic [7:0] code);
    if (code == car_pkg::KEY_GEAR_UP && g < car_pkg::GEAR_MAX) begin
        return g + 3'd1;
    end
    if (code == car_pkg::KEY_GEAR_DOWN && g > car_pkg::GEAR_MIN) begin
        return g - 3'd1;
    end
    return g;
endfunction

// Direction of a drive key.
function automatic car_pkg::drive_t key_cmd(logic [7:0] code);
    case (code)
        car_pkg::KEY_FORWARD:   return car_pkg::DRV_FORWARD;
        car_pkg::KEY_LEFT:      return car_pkg::DRV_LEFT;
        car_pkg::KEY_RIGHT:     return car_pkg::DRV_RIGHT;
        car_pkg::KEY_ARC_LEFT:  return car_pkg::DRV_ARC_LEFT;
        car_pkg::KEY_ARC_RIGHT: return car_pkg::DRV_ARC_RIGHT;
        default:                return car_pkg::DRV_STOP;
    endcase
endfunction

// Camera command once the controller has seen these flags in camera mode.
function automatic car_pkg::drive_t follow_cmd(logic orange, logic [2:0] dir);
    if (!orange) return car_pkg::DRV_RIGHT;
    if (dir[car_pkg::DIR_LEFT]) return car_pkg::DRV_ARC_LEFT;
    if (dir[car_pkg::DIR_CENTER]) return car_pkg::DRV_FORWARD;
    if (dir[car_pkg::DIR_RIGHT]) return car_pkg::DRV_ARC_RIGHT;
    return car_pkg::DRV_STOP;
endfunction

function automatic car_pkg::drive_t arbitrate(logic ir_req, car_pkg::drive_t ir_cmd,
                                              logic cam_req, car_pkg::drive_t cam_cmd,
                                              logic obstacle);
    car_pkg::drive_t sel;
    sel = ir_req ? ir_cmd : (cam_req ? cam_cmd : car_pkg::DRV_STOP);
    if (obstacle && sel == car_pkg::DRV_FORWARD) sel = car_pkg::DRV_STOP;
    return sel;
endfunction

function automatic int wheel_duty(car_pkg::drive_t cmd, logic [car_pkg::GEAR_W-1:0] g,
                                  int period, logic left);
    int base;
    base = int'(g) * period / 4;
    case (cmd)
        car_pkg::DRV_FORWARD, car_pkg::DRV_LEFT, car_pkg::DRV_RIGHT: return base;
        car_pkg::DRV_ARC_LEFT:  return left ? base / 2 : base;
        car_pkg::DRV_ARC_RIGHT: return left ? base : base / 2;
        default:                return 0;
    endcase
endfunction

function automatic logic wheel_rev(car_pkg::drive_t cmd, logic left);
    return (left && cmd == car_pkg::DRV_LEFT) || (!left && cmd == car_pkg::DRV_RIGHT);
endfunction

`endif

// ==== dv/robot_car_tb.sv ====
module robot_car_tb;

    `include "car_model.svh"

    localparam int PERIOD = 16;

    logic                       CLOCK_50;
    logic                       reset;
    logic [7:0]                 ir_code;
    logic                       ir_valid;
    logic [2:0]                 cam_direction;
    logic                       orange_detected;
    logic                       obstacle_near;
    car_pkg::mode_t             mode;
    logic [car_pkg::GEAR_W-1:0] gear;
    car_pkg::drive_t            drive_cmd;
    logic                       grant_ir;
    logic                       grant_cam;
    logic                       left_pwm;
    logic                       right_pwm;
    logic                       left_rev;
    logic                       right_rev;

    int                         checks;
    int                         errors;
    int                         test_errors;
    car_pkg::mode_t             exp_mode;
    logic [car_pkg::GEAR_W-1:0] exp_gear;

    robot_car_top #(
        .PWM_PERIOD (PERIOD)
    ) uut (
        .CLOCK_50        (CLOCK_50),
        .reset           (reset),
        .ir_code         (ir_code),
        .ir_valid        (ir_valid),
        .cam_direction   (cam_direction),
        .orange_detected (orange_detected),
        .obstacle_near   (obstacle_near),
        .mode            (mode),
        .gear            (gear),
        .drive_cmd       (drive_cmd),
        .grant_ir        (grant_ir),
        .grant_cam       (grant_cam),
        .left_pwm        (left_pwm),
        .right_pwm       (right_pwm),
        .left_rev        (left_rev),
        .right_rev       (right_rev)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    initial begin
        #100000;
        $display("Timeout: the test sequence did not reach its end");
        $display("*** FAILED ***");
        $finish;
    end

    // Leaves the caller 1 time unit after the last edge.
    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge CLOCK_50);
        end
        #1;
    endtask

    task automatic send_key(input logic [7:0] code);
        ir_code  = code;
        ir_valid = 1'b1;
        wait_cycles(1);
        ir_valid = 1'b0;
        ir_code  = 8'h00;
        wait_cycles(2);
        exp_mode = next_mode(exp_mode, code);
        exp_gear = next_gear(exp_gear, code);
    endtask

    task automatic check_mode(input string name, input car_pkg::mode_t exp,
                              input car_pkg::mode_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("ERROR %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_gear(input string name, input logic [car_pkg::GEAR_W-1:0] exp,
                              input logic [car_pkg::GEAR_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_cmd(input string name, input car_pkg::drive_t exp,
                             input car_pkg::drive_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("ERROR %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_duty(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            test_errors++;
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic expect_bus(input string name, input logic gi, input logic gc,
                              input car_pkg::drive_t cmd);
        check_flag({name, " grant_ir"}, gi, grant_ir);
        check_flag({name, " grant_cam"}, gc, grant_cam);
        check_cmd({name, " drive_cmd"}, cmd, drive_cmd);
    endtask

    // High cycles of each wheel over one full PWM period.
    task automatic count_high(output int left_n, output int right_n);
        left_n  = 0;
        right_n = 0;
        for (int i = 0; i < PERIOD; i++) begin
            if (left_pwm) left_n++;
            if (right_pwm) right_n++;
            wait_cycles(1);
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    function automatic logic [7:0] drive_key_at(int i);
        case (i)
            0:       return car_pkg::KEY_FORWARD;
            1:       return car_pkg::KEY_LEFT;
            2:       return car_pkg::KEY_RIGHT;
            3:       return car_pkg::KEY_ARC_LEFT;
            4:       return car_pkg::KEY_ARC_RIGHT;
            default: return car_pkg::KEY_STOP;
        endcase
    endfunction

    function automatic logic [7:0] mode_gear_key_at(int i);
        case (i)
            0:       return car_pkg::KEY_CAM;
            1:       return car_pkg::KEY_IR;
            2:       return car_pkg::KEY_IDLE;
            3:       return car_pkg::KEY_GEAR_UP;
            default: return car_pkg::KEY_GEAR_DOWN;
        endcase
    endfunction

    // One-hot or empty direction flags.
    function automatic logic [2:0] dir_pattern(int n);
        case (n)
            0:       return 3'b001;
            1:       return 3'b010;
            2:       return 3'b100;
            default: return 3'b000;
        endcase
    endfunction

    initial begin
        int                         ln;
        int                         rn;
        logic [7:0]                 k;
        logic                       orange;
        logic [2:0]                 dir;
        logic                       obst;
        car_pkg::drive_t            exp_cmd;

        void'($urandom(32'h50b08af4));
        reset           = 1'b1;
        ir_code         = 8'h00;
        ir_valid        = 1'b0;
        cam_direction   = 3'b000;
        orange_detected = 1'b0;
        obstacle_near   = 1'b0;
        checks          = 0;
        errors          = 0;
        test_errors     = 0;
        exp_mode        = car_pkg::MODE_IDLE;
        exp_gear        = car_pkg::GEAR_MIN;
        wait_cycles(5);
        reset = 1'b0;

        check_mode("reset mode", car_pkg::MODE_IDLE, mode);
        check_gear("reset gear", car_pkg::GEAR_MIN, gear);
        expect_bus("reset", 1'b0, 1'b0, car_pkg::DRV_STOP);
        check_flag("reset left_rev", 1'b0, left_rev);
        check_flag("reset right_rev", 1'b0, right_rev);
        count_high(ln, rn);
        check_duty("reset left duty", 0, ln);
        check_duty("reset right duty", 0, rn);
        finish_test("reset_state");

        // Random keys, then a run up and down to hit both gear limits.
        for (int i = 0; i < 30; i++) begin
            if (i < 20) begin
                k = mode_gear_key_at($urandom_range(4, 0));
            end else begin
                k = (i < 25) ? car_pkg::KEY_GEAR_UP : car_pkg::KEY_GEAR_DOWN;
            end
            send_key(k);
            check_mode($sformatf("mode_gear key %0d", i), exp_mode, mode);
            check_gear($sformatf("mode_gear key %0d", i), exp_gear, gear);
        end
        finish_test("mode_gear");

        send_key(car_pkg::KEY_IR);
        check_mode("ir_drive mode", exp_mode, mode);
        for (int o = 0; o < 2; o++) begin
            obstacle_near = o[0];
            for (int i = 0; i < 6; i++) begin
                k = drive_key_at(i);
                send_key(k);
                exp_cmd = arbitrate(1'b1, key_cmd(k), 1'b0, car_pkg::DRV_STOP, o[0]);
                expect_bus($sformatf("ir_drive key %02h obstacle %0d", k, o), 1'b1, 1'b0,
                           exp_cmd);
            end
        end
        obstacle_near = 1'b0;
        finish_test("ir_drive");

        send_key(car_pkg::KEY_CAM);
        check_mode("cam_follow mode", exp_mode, mode);
        expect_bus("cam_follow search", 1'b0, 1'b1, car_pkg::DRV_RIGHT);
        for (int i = 0; i < 24; i++) begin
            orange          = 1'($urandom_range(1, 0));
            dir             = dir_pattern($urandom_range(3, 0));
            obst            = 1'($urandom_range(1, 0));
            orange_detected = orange;
            cam_direction   = dir;
            obstacle_near   = obst;
            wait_cycles(2);
            exp_cmd = arbitrate(1'b0, car_pkg::DRV_STOP, 1'b1, follow_cmd(orange, dir), obst);
            expect_bus($sformatf("cam_follow step %0d", i), 1'b0, 1'b1, exp_cmd);
        end
        finish_test("cam_follow");

        orange_detected = 1'b0;
        cam_direction   = 3'b000;
        obstacle_near   = 1'b0;
        wait_cycles(2);
        send_key(car_pkg::KEY_FORWARD);
        expect_bus("override forward", 1'b1, 1'b0,
                   arbitrate(1'b1, key_cmd(car_pkg::KEY_FORWARD), 1'b1,
                             car_pkg::DRV_RIGHT, 1'b0));
        send_key(car_pkg::KEY_STOP);
        expect_bus("override stop", 1'b0, 1'b1,
                   arbitrate(1'b0, car_pkg::DRV_STOP, 1'b1, car_pkg::DRV_RIGHT, 1'b0));
        send_key(car_pkg::KEY_ARC_LEFT);
        expect_bus("override arc_left", 1'b1, 1'b0,
                   arbitrate(1'b1, key_cmd(car_pkg::KEY_ARC_LEFT), 1'b1,
                             car_pkg::DRV_RIGHT, 1'b0));
        send_key(car_pkg::KEY_IDLE);
        check_mode("override idle mode", exp_mode, mode);
        expect_bus("override idle", 1'b0, 1'b0,
                   arbitrate(1'b0, car_pkg::DRV_STOP, 1'b0, car_pkg::DRV_STOP, 1'b0));
        finish_test("override");

        send_key(car_pkg::KEY_IR);
        for (int g = 1; g <= 4; g++) begin
            for (int j = 0; j < 4 && exp_gear != 3'(g); j++) begin
                send_key(exp_gear < 3'(g) ? car_pkg::KEY_GEAR_UP : car_pkg::KEY_GEAR_DOWN);
            end
            check_gear($sformatf("pwm gear %0d", g), 3'(g), gear);
            for (int i = 0; i < 6; i++) begin
                k = drive_key_at(i);
                send_key(k);
                // Two periods so the new duty is surely latched.
                wait_cycles(2 * PERIOD);
                count_high(ln, rn);
                exp_cmd = key_cmd(k);
                check_duty($sformatf("pwm %s gear %0d left", exp_cmd.name(), g),
                           wheel_duty(exp_cmd, exp_gear, PERIOD, 1'b1), ln);
                check_duty($sformatf("pwm %s gear %0d right", exp_cmd.name(), g),
                           wheel_duty(exp_cmd, exp_gear, PERIOD, 1'b0), rn);
                check_flag($sformatf("pwm %s left_rev", exp_cmd.name()),
                           wheel_rev(exp_cmd, 1'b1), left_rev);
                check_flag($sformatf("pwm %s right_rev", exp_cmd.name()),
                           wheel_rev(exp_cmd, 1'b0), right_rev);
            end
        end
        finish_test("pwm_duty");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+dv
verilog/car_pkg.sv
verilog/mode_fsm.sv
verilog/ir_drive_ctrl.sv
verilog/cam_follow_ctrl.sv
verilog/drive_arbiter.sv
verilog/motor_pwm.sv
verilog/robot_car_top.sv
dv/robot_car_tb.sv

// ==== verilog/cam_follow_ctrl.sv ====
module cam_follow_ctrl (
    input  logic            CLOCK_50,
    input  logic            reset,
    input  car_pkg::mode_t  mode,
    input  logic [2:0]      cam_direction,
    input  logic            orange_detected,
    output logic            cam_req,
    output car_pkg::drive_t cam_cmd
);

    car_pkg::cam_state_t state;
    car_pkg::cam_state_t state_next;
    logic [2:0]          dir_q;

    always_comb begin
        state_next = state;
        case (state)
            car_pkg::CAM_PAUSE: begin
                if (mode == car_pkg::MODE_CAM) begin
                    state_next = car_pkg::CAM_SEARCH;
                end
            end
            car_pkg::CAM_SEARCH: begin
                if (mode != car_pkg::MODE_CAM) begin
                    state_next = car_pkg::CAM_PAUSE;
                end else if (orange_detected) begin
                    state_next = car_pkg::CAM_FOLLOW;
                end
            end
            car_pkg::CAM_FOLLOW: begin
                if (mode != car_pkg::MODE_CAM) begin
                    state_next = car_pkg::CAM_PAUSE;
                end else if (!orange_detected) begin
                    state_next = car_pkg::CAM_SEARCH;
                end
            end
            default: begin
                state_next = car_pkg::CAM_PAUSE;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            state <= car_pkg::CAM_PAUSE;
        end else begin
            state <= state_next;
        end
        dir_q <= cam_direction;
    end

    assign cam_req = (state == car_pkg::CAM_SEARCH) || (state == car_pkg::CAM_FOLLOW);

    // Spin right while searching.
    always_comb begin
        cam_cmd = car_pkg::DRV_STOP;
        if (state == car_pkg::CAM_SEARCH) begin
            cam_cmd = car_pkg::DRV_RIGHT;
        end else if (state == car_pkg::CAM_FOLLOW) begin
            if (dir_q[car_pkg::DIR_LEFT]) begin
                cam_cmd = car_pkg::DRV_ARC_LEFT;
            end else if (dir_q[car_pkg::DIR_CENTER]) begin
                cam_cmd = car_pkg::DRV_FORWARD;
            end else if (dir_q[car_pkg::DIR_RIGHT]) begin
                cam_cmd = car_pkg::DRV_ARC_RIGHT;
            end
        end
    end

endmodule

// ==== verilog/car_pkg.sv ====
package car_pkg;

    // Operating modes.
    typedef enum logic [1:0] {
        MODE_IDLE = 2'b00,
        MODE_CAM  = 2'b01,
        MODE_IR   = 2'b10
    } mode_t;

    // Commands carried on the shared motor bus.
    typedef enum logic [2:0] {
        DRV_STOP      = 3'b000,
        DRV_FORWARD   = 3'b001,
        DRV_LEFT      = 3'b010,
        DRV_RIGHT     = 3'b011,
        DRV_ARC_LEFT  = 3'b100,
        DRV_ARC_RIGHT = 3'b101
    } drive_t;

    // Camera follow sub-states.
    typedef enum logic [1:0] {
        CAM_SEARCH = 2'b00,
        CAM_FOLLOW = 2'b01,
        CAM_PAUSE  = 2'b11
    } cam_state_t;

    // Remote mode keys.
    localparam logic [7:0] KEY_CAM  = 8'h0F;
    localparam logic [7:0] KEY_IR   = 8'h13;
    localparam logic [7:0] KEY_IDLE = 8'h10;

    // Remote drive keys.
    localparam logic [7:0] KEY_FORWARD   = 8'h05;
    localparam logic [7:0] KEY_LEFT      = 8'h07;
    localparam logic [7:0] KEY_RIGHT     = 8'h09;
    localparam logic [7:0] KEY_ARC_LEFT  = 8'h04;
    localparam logic [7:0] KEY_ARC_RIGHT = 8'h06;
    localparam logic [7:0] KEY_STOP      = 8'h08;

    // Gear keys and range.
    localparam logic [7:0] KEY_GEAR_UP   = 8'h1A;
    localparam logic [7:0] KEY_GEAR_DOWN = 8'h1E;
    localparam int GEAR_W = 3;
    localparam logic [GEAR_W-1:0] GEAR_MIN = 3'd1;
    localparam logic [GEAR_W-1:0] GEAR_MAX = 3'd4;

    // Bit positions in cam_direction.
    localparam int DIR_LEFT   = 0;
    localparam int DIR_CENTER = 1;
    localparam int DIR_RIGHT  = 2;

endpackage

// ==== verilog/drive_arbiter.sv ====
module drive_arbiter (
    input  logic            CLOCK_50,
    input  logic            reset,
    input  logic            ir_req,
    input  car_pkg::drive_t ir_cmd,
    input  logic            cam_req,
    input  car_pkg::drive_t cam_cmd,
    input  logic            obstacle_near,
    output logic            grant_ir,
    output logic            grant_cam,
    output car_pkg::drive_t drive_cmd
);

    car_pkg::drive_t sel_cmd;
    logic            next_grant_ir;
    logic            next_grant_cam;

    // Fixed priority, IR first.
    always_comb begin
        next_grant_ir  = ir_req;
        next_grant_cam = !ir_req && cam_req;
        if (next_grant_ir) begin
            sel_cmd = ir_cmd;
        end else if (next_grant_cam) begin
            sel_cmd = cam_cmd;
        end else begin
            sel_cmd = car_pkg::DRV_STOP;
        end
        // Obstacle blocks forward only, turns still pass.
        if (obstacle_near && sel_cmd == car_pkg::DRV_FORWARD) begin
            sel_cmd = car_pkg::DRV_STOP;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            grant_ir  <= 1'b0;
            grant_cam <= 1'b0;
            drive_cmd <= car_pkg::DRV_STOP;
        end else begin
            grant_ir  <= next_grant_ir;
            grant_cam <= next_grant_cam;
            drive_cmd <= sel_cmd;
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (reset)
        !(grant_ir && grant_cam));

    // Each grant is backed by a request one cycle earlier.
    assert property (@(posedge CLOCK_50) disable iff (reset)
        grant_ir |-> $past(ir_req));

    assert property (@(posedge CLOCK_50) disable iff (reset)
        grant_cam |-> $past(cam_req));

endmodule

// ==== verilog/ir_drive_ctrl.sv ====
module ir_drive_ctrl (
    input  logic            CLOCK_50,
    input  logic            reset,
    input  logic [7:0]      ir_code,
    input  logic            ir_valid,
    input  car_pkg::mode_t  mode,
    input  logic            grant_ir,
    output logic            ir_req,
    output car_pkg::drive_t ir_cmd
);

    car_pkg::drive_t held_cmd;
    car_pkg::drive_t key_cmd;
    logic            is_drive_key;
    logic            mode_change;

    // Drive key decode.
    always_comb begin
        is_drive_key = 1'b1;
        key_cmd = car_pkg::DRV_STOP;
        case (ir_code)
            car_pkg::KEY_FORWARD:   key_cmd = car_pkg::DRV_FORWARD;
            car_pkg::KEY_LEFT:      key_cmd = car_pkg::DRV_LEFT;
            car_pkg::KEY_RIGHT:     key_cmd = car_pkg::DRV_RIGHT;
            car_pkg::KEY_ARC_LEFT:  key_cmd = car_pkg::DRV_ARC_LEFT;
            car_pkg::KEY_ARC_RIGHT: key_cmd = car_pkg::DRV_ARC_RIGHT;
            car_pkg::KEY_STOP:      key_cmd = car_pkg::DRV_STOP;
            default:                is_drive_key = 1'b0;
        endcase
    end

    // A mode key changes the mode only if it names a different one,
    // so the clear lines up with the mode register update.
    always_comb begin
        mode_change = 1'b0;
        if (ir_valid) begin
            case (ir_code)
                car_pkg::KEY_CAM:  mode_change = (mode != car_pkg::MODE_CAM);
                car_pkg::KEY_IR:   mode_change = (mode != car_pkg::MODE_IR);
                car_pkg::KEY_IDLE: mode_change = (mode != car_pkg::MODE_IDLE);
                default:           mode_change = 1'b0;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            held_cmd <= car_pkg::DRV_STOP;
        end else if (mode == car_pkg::MODE_IDLE || mode_change) begin
            held_cmd <= car_pkg::DRV_STOP;
        end else if (ir_valid && is_drive_key) begin
            held_cmd <= key_cmd;
        end
    end

    // In camera mode a held drive key is the manual override.
    always_comb begin
        case (mode)
            car_pkg::MODE_IR:  ir_req = 1'b1;
            car_pkg::MODE_CAM: ir_req = (held_cmd != car_pkg::DRV_STOP);
            default:           ir_req = 1'b0;
        endcase
    end

    assign ir_cmd = held_cmd;

    // IR has top priority, so its request always wins the next grant.
    assert property (@(posedge CLOCK_50) disable iff (reset)
        ir_req |=> grant_ir);

endmodule

// ==== verilog/mode_fsm.sv ====
module mode_fsm (
    input  logic                         CLOCK_50,
    input  logic                         reset,
    input  logic [7:0]                   ir_code,
    input  logic                         ir_valid,
    output car_pkg::mode_t               mode,
    output logic [car_pkg::GEAR_W-1:0]   gear
);

    car_pkg::mode_t mode_next;

    always_comb begin
        mode_next = mode;
        case (mode)
            car_pkg::MODE_IDLE: begin
                if (ir_code == car_pkg::KEY_CAM) begin
                    mode_next = car_pkg::MODE_CAM;
                end else if (ir_code == car_pkg::KEY_IR) begin
                    mode_next = car_pkg::MODE_IR;
                end
            end
            car_pkg::MODE_CAM: begin
                if (ir_code == car_pkg::KEY_IR) begin
                    mode_next = car_pkg::MODE_IR;
                end else if (ir_code == car_pkg::KEY_IDLE) begin
                    mode_next = car_pkg::MODE_IDLE;
                end
            end
            car_pkg::MODE_IR: begin
                if (ir_code == car_pkg::KEY_CAM) begin
                    mode_next = car_pkg::MODE_CAM;
                end else if (ir_code == car_pkg::KEY_IDLE) begin
                    mode_next = car_pkg::MODE_IDLE;
                end
            end
            default: begin
                mode_next = car_pkg::MODE_IDLE;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            mode <= car_pkg::MODE_IDLE;
            gear <= car_pkg::GEAR_MIN;
        end else if (ir_valid) begin
            mode <= mode_next;
            // Gear saturates at both ends.
            if (ir_code == car_pkg::KEY_GEAR_UP && gear != car_pkg::GEAR_MAX) begin
                gear <= gear + 1'b1;
            end else if (ir_code == car_pkg::KEY_GEAR_DOWN && gear != car_pkg::GEAR_MIN) begin
                gear <= gear - 1'b1;
            end
        end
    end

    // Gear stays within range.
    assert property (@(posedge CLOCK_50) disable iff (reset)
        gear >= car_pkg::GEAR_MIN && gear <= car_pkg::GEAR_MAX);

endmodule

// ==== verilog/motor_pwm.sv ====
module motor_pwm #(
    parameter int PWM_PERIOD = 1000
) (
    input  logic                       CLOCK_50,
    input  logic                       reset,
    input  car_pkg::drive_t            drive_cmd,
    input  logic [car_pkg::GEAR_W-1:0] gear,
    output logic                       left_pwm,
    output logic                       right_pwm,
    output logic                       left_rev,
    output logic                       right_rev
);

    localparam int CNT_W  = $clog2(PWM_PERIOD);
    localparam int DUTY_W = $clog2(PWM_PERIOD + 1);
    localparam logic [DUTY_W-1:0] QUARTER = DUTY_W'(PWM_PERIOD / 4);

    logic [CNT_W-1:0]  cnt;
    logic              wrap;
    logic [DUTY_W-1:0] base_duty;
    logic [DUTY_W-1:0] half_duty;
    logic [DUTY_W-1:0] left_next;
    logic [DUTY_W-1:0] right_next;
    logic              left_rev_next;
    logic              right_rev_next;
    logic [DUTY_W-1:0] left_duty;
    logic [DUTY_W-1:0] right_duty;

    assign wrap      = (cnt == CNT_W'(PWM_PERIOD - 1));
    assign base_duty = DUTY_W'(gear) * QUARTER;
    assign half_duty = base_duty >> 1;

    always_comb begin
        left_next      = '0;
        right_next     = '0;
        left_rev_next  = 1'b0;
        right_rev_next = 1'b0;
        case (drive_cmd)
            car_pkg::DRV_FORWARD: begin
                left_next  = base_duty;
                right_next = base_duty;
            end
            car_pkg::DRV_ARC_LEFT: begin
                left_next  = half_duty;
                right_next = base_duty;
            end
            car_pkg::DRV_ARC_RIGHT: begin
                left_next  = base_duty;
                right_next = half_duty;
            end
            car_pkg::DRV_LEFT: begin
                left_next     = base_duty;
                right_next    = base_duty;
                left_rev_next = 1'b1;
            end
            car_pkg::DRV_RIGHT: begin
                left_next      = base_duty;
                right_next     = base_duty;
                right_rev_next = 1'b1;
            end
            default: begin
                left_next  = '0;
                right_next = '0;
            end
        endcase
    end

    // New duty and direction load as the counter wraps.
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            cnt        <= '0;
            left_duty  <= '0;
            right_duty <= '0;
            left_rev   <= 1'b0;
            right_rev  <= 1'b0;
        end else if (wrap) begin
            cnt        <= '0;
            left_duty  <= left_next;
            right_duty <= right_next;
            left_rev   <= left_rev_next;
            right_rev  <= right_rev_next;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign left_pwm  = (DUTY_W'(cnt) < left_duty);
    assign right_pwm = (DUTY_W'(cnt) < right_duty);

    // Holds only while the gear from mode_fsm stays in range.
    assert property (@(posedge CLOCK_50) disable iff (reset)
        left_duty <= DUTY_W'(PWM_PERIOD) && right_duty <= DUTY_W'(PWM_PERIOD));

endmodule

// ==== verilog/robot_car_top.sv ====
module robot_car_top #(
    parameter int PWM_PERIOD = 1000
) (
    input  logic                       CLOCK_50,
    input  logic                       reset,
    input  logic [7:0]                 ir_code,
    input  logic                       ir_valid,
    input  logic [2:0]                 cam_direction,
    input  logic                       orange_detected,
    input  logic                       obstacle_near,
    output car_pkg::mode_t             mode,
    output logic [car_pkg::GEAR_W-1:0] gear,
    output car_pkg::drive_t            drive_cmd,
    output logic                       grant_ir,
    output logic                       grant_cam,
    output logic                       left_pwm,
    output logic                       right_pwm,
    output logic                       left_rev,
    output logic                       right_rev
);

    logic            ir_req;
    car_pkg::drive_t ir_cmd;
    logic            cam_req;
    car_pkg::drive_t cam_cmd;

    mode_fsm u_mode_fsm (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .ir_code  (ir_code),
        .ir_valid (ir_valid),
        .mode     (mode),
        .gear     (gear)
    );

    ir_drive_ctrl u_ir_drive_ctrl (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .ir_code  (ir_code),
        .ir_valid (ir_valid),
        .mode     (mode),
        .grant_ir (grant_ir),
        .ir_req   (ir_req),
        .ir_cmd   (ir_cmd)
    );

    cam_follow_ctrl u_cam_follow_ctrl (
        .CLOCK_50        (CLOCK_50),
        .reset           (reset),
        .mode            (mode),
        .cam_direction   (cam_direction),
        .orange_detected (orange_detected),
        .cam_req         (cam_req),
        .cam_cmd         (cam_cmd)
    );

    drive_arbiter u_drive_arbiter (
        .CLOCK_50      (CLOCK_50),
        .reset         (reset),
        .ir_req        (ir_req),
        .ir_cmd        (ir_cmd),
        .cam_req       (cam_req),
        .cam_cmd       (cam_cmd),
        .obstacle_near (obstacle_near),
        .grant_ir      (grant_ir),
        .grant_cam     (grant_cam),
        .drive_cmd     (drive_cmd)
    );

    motor_pwm #(
        .PWM_PERIOD (PWM_PERIOD)
    ) u_motor_pwm (
        .CLOCK_50  (CLOCK_50),
        .reset     (reset),
        .drive_cmd (drive_cmd),
        .gear      (gear),
        .left_pwm  (left_pwm),
        .right_pwm (right_pwm),
        .left_rev  (left_rev),
        .right_rev (right_rev)
    );

endmodule
